/* hw/spi_bit_timer.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_bit_timer #(
    parameter int DIVIDER_WIDTH = 16
) (
    input  logic                       clock,
    input  logic                       reset_n,
    input  logic                       run,
    input  logic [DIVIDER_WIDTH-1:0]   divider,
    output logic                       tick,
    output spi_timing_pkg::step_t      step
);

    logic [DIVIDER_WIDTH-1:0] count;

    // Free running, one tick every divider+1 cycles
    assign tick = count >= divider;

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            count <= '0;
        end else if (tick) begin
            count <= '0;
        end else begin
            count <= count + 1'b1;
        end
    end

    // Quarter of the current bit
    always_ff @(posedge clock) begin
        if (!reset_n) begin
            step <= '0;
        end else if (!run) begin
            step <= '0;
        end else if (tick) begin
            if (step == spi_timing_pkg::step_t'(spi_timing_pkg::FRAME_STEPS - 1)) begin
                step <= '0;
            end else begin
                step <= step + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* hw/spi_frame_pkg.sv */
`default_nettype none

package spi_frame_pkg;

    ////////////////////////////////////////
    // Field widths
    ////////////////////////////////////////

    localparam int ADDRESS_WIDTH = 7;
    localparam int DATA_WIDTH    = 8;

    // Address, read/write bit, data
    localparam int FRAME_WIDTH   = ADDRESS_WIDTH + 1 + DATA_WIDTH;

    // One frame, seen as fields or as a raw shift word
    typedef union packed {
        struct packed {
            logic [ADDRESS_WIDTH-1:0] address;
            logic                     read_write;
            logic [DATA_WIDTH-1:0]    data;
        } fields;
        logic [FRAME_WIDTH-1:0] raw;
    } frame_t;

endpackage

`default_nettype wire

/* hw/spi_master.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_master #(
    parameter int DIVIDER_WIDTH = 16
) (
    input  logic                                    clock,
    input  logic                                    reset_n,
    input  logic                                    enable,
    input  logic [spi_frame_pkg::ADDRESS_WIDTH-1:0] address,
    input  logic                                    read_write,
    input  logic [spi_frame_pkg::DATA_WIDTH-1:0]    data,
    input  logic                                    clock_phase,
    input  logic [DIVIDER_WIDTH-1:0]                divider,
    input  logic                                    master_in_slave_out,
    output logic                                    serial_clock,
    output logic                                    slave_select,
    output logic                                    master_out_slave_in,
    output logic                                    busy,
    output logic [spi_frame_pkg::DATA_WIDTH-1:0]    read_data
);

    logic                   run;
    logic                   tick;
    spi_timing_pkg::step_t  step;
    logic                   load;
    logic                   drive_bit;
    logic                   sample_bit;
    logic                   capture;

    ////////////////////////////////////////
    // Timing and control
    ////////////////////////////////////////

    spi_bit_timer #(
        .DIVIDER_WIDTH(DIVIDER_WIDTH)
    ) bit_timer (
        .clock   (clock),
        .reset_n (reset_n),
        .run     (run),
        .divider (divider),
        .tick    (tick),
        .step    (step)
    );

    spi_sequencer sequencer (
        .clock        (clock),
        .reset_n      (reset_n),
        .enable       (enable),
        .clock_phase  (clock_phase),
        .tick         (tick),
        .step         (step),
        .run          (run),
        .load         (load),
        .drive_bit    (drive_bit),
        .sample_bit   (sample_bit),
        .capture      (capture),
        .busy         (busy),
        .slave_select (slave_select),
        .serial_clock (serial_clock)
    );

    ////////////////////////////////////////
    // Datapath
    ////////////////////////////////////////

    spi_shift_transmit shift_transmit (
        .clock               (clock),
        .reset_n             (reset_n),
        .load                (load),
        .drive_bit           (drive_bit),
        .address             (address),
        .read_write          (read_write),
        .data                (data),
        .master_out_slave_in (master_out_slave_in)
    );

    spi_shift_receive shift_receive (
        .clock               (clock),
        .reset_n             (reset_n),
        .sample_bit          (sample_bit),
        .capture             (capture),
        .master_in_slave_out (master_in_slave_out),
        .read_data           (read_data)
    );

endmodule

`default_nettype wire

/* hw/spi_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_sequencer (
    input  logic                    clock,
    input  logic                    reset_n,
    input  logic                    enable,
    input  logic                    clock_phase,
    input  logic                    tick,
    input  spi_timing_pkg::step_t   step,
    output logic                    run,
    output logic                    load,
    output logic                    drive_bit,
    output logic                    sample_bit,
    output logic                    capture,
    output logic                    busy,
    output logic                    slave_select,
    output logic                    serial_clock
);

    localparam int BIT_COUNT_WIDTH = $clog2(spi_frame_pkg::FRAME_WIDTH);
    localparam logic [BIT_COUNT_WIDTH-1:0] LAST_BIT =
        BIT_COUNT_WIDTH'(spi_frame_pkg::FRAME_WIDTH - 1);

    spi_timing_pkg::state_t         state;
    logic                           saved_phase;
    logic [BIT_COUNT_WIDTH-1:0]     bit_count;
    logic                           shift_tick;
    logic                           stop_tick;
    logic                           last_bit;

    assign shift_tick = tick && (state == spi_timing_pkg::SHIFT);
    assign stop_tick  = tick && (state == spi_timing_pkg::STOP);
    assign last_bit   = bit_count == LAST_BIT;

    // Command accepted only while idle
    assign load = enable && !busy;

    // Step counter walks through SHIFT and STOP
    assign run = (state == spi_timing_pkg::SHIFT) || (state == spi_timing_pkg::STOP);

    assign capture = stop_tick && (step == spi_timing_pkg::step_t'(1));

    ////////////////////////////////////////
    // Drive and sample strobes
    ////////////////////////////////////////

    always_comb begin
        drive_bit  = 1'b0;
        sample_bit = 1'b0;

        // CPHA 0 puts the first bit out with select
        if (state == spi_timing_pkg::IDLE && busy && tick && !saved_phase) begin
            drive_bit = 1'b1;
        end

        if (shift_tick) begin
            case (step)
                spi_timing_pkg::step_t'(0): sample_bit = saved_phase && (bit_count != '0);
                spi_timing_pkg::step_t'(1): drive_bit  = saved_phase;
                spi_timing_pkg::step_t'(2): sample_bit = !saved_phase;
                default:                    drive_bit  = !saved_phase && !last_bit;
            endcase
        end

        // Last CPHA 1 bit arrives after the final falling edge
        if (stop_tick && step == spi_timing_pkg::step_t'(0)) begin
            sample_bit = saved_phase;
        end
    end

    ////////////////////////////////////////
    // State and line levels
    ////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            state        <= spi_timing_pkg::IDLE;
            busy         <= 1'b0;
            slave_select <= 1'b1;
            serial_clock <= 1'b0;
            saved_phase  <= 1'b0;
            bit_count    <= '0;
        end else begin
            case (state)
                spi_timing_pkg::IDLE: begin
                    if (load) begin
                        busy        <= 1'b1;
                        saved_phase <= clock_phase;
                    end else if (busy && tick) begin
                        state        <= spi_timing_pkg::SELECT;
                        slave_select <= 1'b0;
                    end
                end
                spi_timing_pkg::SELECT: begin
                    if (tick) begin
                        state <= spi_timing_pkg::SHIFT;
                    end
                end
                spi_timing_pkg::SHIFT: begin
                    if (tick && step == spi_timing_pkg::step_t'(1)) begin
                        serial_clock <= 1'b1;
                    end
                    if (tick && step == spi_timing_pkg::step_t'(3)) begin
                        serial_clock <= 1'b0;
                        bit_count    <= bit_count + 1'b1;
                        if (last_bit) begin
                            state <= spi_timing_pkg::STOP;
                        end
                    end
                end
                default: begin
                    if (tick && step == spi_timing_pkg::step_t'(1)) begin
                        slave_select <= 1'b1;
                    end
                    if (tick && step == spi_timing_pkg::step_t'(3)) begin
                        busy  <= 1'b0;
                        state <= spi_timing_pkg::IDLE;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* hw/spi_shift_receive.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_shift_receive (
    input  logic                                    clock,
    input  logic                                    reset_n,
    input  logic                                    sample_bit,
    input  logic                                    capture,
    input  logic                                    master_in_slave_out,
    output logic [spi_frame_pkg::DATA_WIDTH-1:0]    read_data
);

    spi_frame_pkg::frame_t frame;

    // Incoming frame, first bit ends up on top
    always_ff @(posedge clock) begin
        if (sample_bit) begin
            frame.raw <= {frame.raw[spi_frame_pkg::FRAME_WIDTH-2:0], master_in_slave_out};
        end
    end

    // Only the data field is handed to the host
    always_ff @(posedge clock) begin
        if (!reset_n) begin
            read_data <= '0;
        end else if (capture) begin
            read_data <= frame.fields.data;
        end
    end

endmodule

`default_nettype wire

/* hw/spi_shift_transmit.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_shift_transmit (
    input  logic                                    clock,
    input  logic                                    reset_n,
    input  logic                                    load,
    input  logic                                    drive_bit,
    input  logic [spi_frame_pkg::ADDRESS_WIDTH-1:0] address,
    input  logic                                    read_write,
    input  logic [spi_frame_pkg::DATA_WIDTH-1:0]    data,
    output logic                                    master_out_slave_in
);

    spi_frame_pkg::frame_t frame;

    // Build from fields, shift out through the raw view
    always_ff @(posedge clock) begin
        if (load) begin
            frame.fields.address    <= address;
            frame.fields.read_write <= read_write;
            frame.fields.data       <= data;
        end else if (drive_bit) begin
            frame.raw <= {frame.raw[spi_frame_pkg::FRAME_WIDTH-2:0], 1'b0};
        end
    end

    // MSB first
    always_ff @(posedge clock) begin
        if (!reset_n) begin
            master_out_slave_in <= 1'b0;
        end else if (drive_bit) begin
            master_out_slave_in <= frame.raw[spi_frame_pkg::FRAME_WIDTH-1];
        end
    end

endmodule

`default_nettype wire

/* hw/spi_timing_pkg.sv */
`default_nettype none

package spi_timing_pkg;

    ////////////////////////////////////////
    // Sequencer states
    ////////////////////////////////////////

    typedef enum logic [1:0] {
        IDLE,
        SELECT,
        SHIFT,
        STOP
    } state_t;

    ////////////////////////////////////////
    // Bit steps
    ////////////////////////////////////////

    // 0 low half, 1 rising edge, 2 high half, 3 falling edge
    typedef logic [1:0] step_t;

    localparam int FRAME_STEPS = 4;

endpackage

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Build and run the SPI master testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f spi_master.f --top-module spi_master_tb -Mdir obj_dir

# Keep running past assertion errors so the testbench reports them
output=$(./obj_dir/Vspi_master_tb +verilator+error+limit+1000)
echo "$output"

if echo "$output" | grep -q "^TESTS PASSED$"; then
    exit 0
fi
exit 1

/* sim/spi_master_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_master_properties (
    input logic clock,
    input logic reset_n,
    input logic enable,
    input logic busy,
    input logic slave_select,
    input logic serial_clock
);

    int failures = 0;

    // Select stays inactive between transfers
    select_idle: assert property (
        @(posedge clock) disable iff (!reset_n) !busy |-> slave_select
    ) else begin
        $error("slave_select active while busy is low");
        failures++;
    end

    // No serial clock without select
    clock_idle: assert property (
        @(posedge clock) disable iff (!reset_n) slave_select |-> !serial_clock
    ) else begin
        $error("serial_clock high while slave_select is high");
        failures++;
    end

    accept_command: assert property (
        @(posedge clock) disable iff (!reset_n) enable && !busy |=> busy
    ) else begin
        $error("busy not raised after an accepted command");
        failures++;
    end

endmodule

bind spi_master spi_master_properties properties (
    .clock        (clock),
    .reset_n      (reset_n),
    .enable       (enable),
    .busy         (busy),
    .slave_select (slave_select),
    .serial_clock (serial_clock)
);

`default_nettype wire

/* sim/spi_master_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_master_tb;

    localparam int DIVIDER_WIDTH  = 8;
    localparam int CLOCK_PERIOD   = 20;
    localparam int DRIVE_DELAY    = 2;
    localparam int TRANSFER_COUNT = 25;
    localparam int MAX_DIVIDER    = 5;
    // Worst case of 70*(divider+1)+2 cycles per transfer and a margin
    localparam int WATCHDOG_CYCLES = TRANSFER_COUNT * (70 * (MAX_DIVIDER + 1) + 2) + 500;

    logic                     clock;
    logic                     reset_n;
    logic                     enable;
    logic [6:0]               address;
    logic                     read_write;
    logic [7:0]               data;
    logic                     clock_phase;
    logic [DIVIDER_WIDTH-1:0] divider;
    logic                     master_in_slave_out;
    logic                     serial_clock;
    logic                     slave_select;
    logic                     master_out_slave_in;
    logic                     busy;
    logic [7:0]               read_data;

    int         errors;
    int         high_min;
    int         high_max;
    int         high_periods;
    logic [7:0] expected_memory [128];

    // Slave model state
    logic [7:0]  memory [128];
    logic [15:0] rx_shift;
    logic [15:0] last_frame;
    logic [6:0]  slave_address;
    logic        slave_read;
    int          rx_count;
    int          miso_index;
    int          frame_count;

    spi_master #(
        .DIVIDER_WIDTH(DIVIDER_WIDTH)
    ) uut (
        .clock               (clock),
        .reset_n             (reset_n),
        .enable              (enable),
        .address             (address),
        .read_write          (read_write),
        .data                (data),
        .clock_phase         (clock_phase),
        .divider             (divider),
        .master_in_slave_out (master_in_slave_out),
        .serial_clock        (serial_clock),
        .slave_select        (slave_select),
        .master_out_slave_in (master_out_slave_in),
        .busy                (busy),
        .read_data           (read_data)
    );

    initial begin
        clock = 1'b0;
        forever #(CLOCK_PERIOD / 2) clock = ~clock;
    end

    function automatic logic [7:0] fill_pattern(input int index);
        return 8'(index * 37) ^ 8'hC3;
    endfunction

    function automatic void report_mismatch(input string name, input logic [15:0] expected,
                                            input logic [15:0] actual);
        $display("Fail %0t %s expected %h got %h", $time, name, expected, actual);
        errors++;
    endfunction

    ////////////////////////////////////////
    // SPI slave model
    ////////////////////////////////////////

    // Data field of a read comes from memory and the rest is zero
    function automatic logic miso_bit(input int index);
        if (index >= 8 && index < 16 && slave_read) begin
            return memory[slave_address][3'(15 - index)];
        end
        return 1'b0;
    endfunction

    task automatic drive_miso();
        #(DRIVE_DELAY);
        master_in_slave_out = miso_bit(miso_index);
        miso_index++;
    endtask

    task automatic receive_bit();
        rx_shift = {rx_shift[14:0], master_out_slave_in};
        rx_count++;
        if (rx_count == 8) begin
            slave_address = rx_shift[7:1];
            slave_read    = rx_shift[0];
        end
    endtask

    initial begin
        logic last_select;
        logic last_clock;
        for (int i = 0; i < 128; i++) begin
            memory[i] = fill_pattern(i);
        end
        master_in_slave_out = 1'b0;
        rx_shift      = '0;
        last_frame    = '0;
        slave_address = '0;
        slave_read    = 1'b0;
        rx_count      = 0;
        miso_index    = 0;
        frame_count   = 0;
        last_select   = 1'b1;
        last_clock    = 1'b0;
        forever begin
            @(serial_clock or slave_select);
            if (reset_n) begin
                if (last_select && !slave_select) begin
                    rx_count   = 0;
                    miso_index = 0;
                    slave_read = 1'b0;
                    if (!clock_phase) begin
                        drive_miso();
                    end
                end
                if (!last_select && slave_select) begin
                    frame_count++;
                    last_frame = rx_shift;
                    if (rx_count == 16 && !rx_shift[8]) begin
                        memory[rx_shift[15:9]] = rx_shift[7:0];
                    end
                end
                // Sample on the phase edge and drive on the other one
                if (serial_clock !== last_clock && !slave_select) begin
                    if (serial_clock != clock_phase) begin
                        receive_bit();
                    end else begin
                        drive_miso();
                    end
                end
            end
            last_select = slave_select;
            last_clock  = serial_clock;
        end
    end

    ////////////////////////////////////////
    // Command helpers
    ////////////////////////////////////////

    task automatic start_command(input logic rw, input logic [6:0] addr, input logic [7:0] value);
        address    = addr;
        read_write = rw;
        data       = value;
        enable     = 1'b1;
        @(posedge clock);
        #(DRIVE_DELAY);
        enable = 1'b0;
        if (busy !== 1'b1)
            report_mismatch("busy", 16'h1, {15'h0, busy});
    endtask

    // Also measures every serial clock high period on the way
    task automatic wait_idle();
        int limit;
        int cycles;
        int high_run;
        limit        = 70 * (int'(divider) + 1) + 2;
        cycles       = 0;
        high_run     = 0;
        high_min     = limit;
        high_max     = 0;
        high_periods = 0;
        while (busy && cycles < limit) begin
            @(posedge clock);
            #(DRIVE_DELAY);
            cycles++;
            if (serial_clock) begin
                high_run++;
            end else if (high_run != 0) begin
                high_min     = (high_run < high_min) ? high_run : high_min;
                high_max     = (high_run > high_max) ? high_run : high_max;
                high_periods++;
                high_run     = 0;
            end
        end
        if (busy) begin
            $display("Error at %0t, busy did not fall within %0d cycles", $time, limit);
            errors++;
        end
    endtask

    ////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////

    task automatic reset_state_test();
        if (busy !== 1'b0)
            report_mismatch("busy", 16'h0, {15'h0, busy});
        if (slave_select !== 1'b1)
            report_mismatch("slave_select", 16'h1, {15'h0, slave_select});
        if (serial_clock !== 1'b0)
            report_mismatch("serial_clock", 16'h0, {15'h0, serial_clock});
        if (master_out_slave_in !== 1'b0)
            report_mismatch("master_out_slave_in", 16'h0, {15'h0, master_out_slave_in});
        if (read_data !== 8'h00)
            report_mismatch("read_data", 16'h0, {8'h0, read_data});
    endtask

    task automatic write_test(input logic phase, input int div, input logic [6:0] addr,
                              input logic [7:0] value);
        int frames;
        frames      = frame_count;
        clock_phase = phase;
        divider     = DIVIDER_WIDTH'(div);
        start_command(1'b0, addr, value);
        wait_idle();
        expected_memory[addr] = value;
        if (frame_count != frames + 1)
            report_mismatch("frame_count", 16'(frames + 1), 16'(frame_count));
        if (last_frame !== {addr, 1'b0, value})
            report_mismatch("slave frame", {addr, 1'b0, value}, last_frame);
        if (memory[addr] !== value)
            report_mismatch("slave memory", {8'h0, value}, {8'h0, memory[addr]});
    endtask

    task automatic read_test(input logic phase, input int div, input logic [6:0] addr);
        clock_phase = phase;
        divider     = DIVIDER_WIDTH'(div);
        start_command(1'b1, addr, 8'($urandom));
        wait_idle();
        if (read_data !== expected_memory[addr])
            report_mismatch("read_data", {8'h0, expected_memory[addr]}, {8'h0, read_data});
    endtask

    task automatic read_back_test(input logic phase, input int div, input int count);
        logic [6:0] addr;
        for (int i = 0; i < count; i++) begin
            addr = 7'($urandom);
            write_test(phase, div, addr, 8'($urandom));
            read_test(phase, div, addr);
        end
    endtask

    task automatic divider_test(input int div);
        logic [6:0] addr;
        addr = 7'($urandom);
        write_test(1'b0, div, addr, 8'($urandom));
        if (high_periods != 16)
            report_mismatch("serial_clock pulses", 16'd16, 16'(high_periods));
        if (high_min != 2 * (div + 1))
            report_mismatch("serial_clock high min", 16'(2 * (div + 1)), 16'(high_min));
        if (high_max != 2 * (div + 1))
            report_mismatch("serial_clock high max", 16'(2 * (div + 1)), 16'(high_max));
        read_test(1'b0, div, addr);
    endtask

    task automatic enable_busy_test();
        logic [6:0] first_address;
        logic [7:0] first_data;
        int         frames;
        first_address = 7'($urandom);
        first_data    = 8'($urandom);
        frames        = frame_count;
        clock_phase   = 1'b0;
        divider       = DIVIDER_WIDTH'(1);
        start_command(1'b0, first_address, first_data);
        repeat (10) @(posedge clock);
        #(DRIVE_DELAY);
        // Second command in the middle of the frame
        address = first_address ^ 7'h55;
        data    = ~first_data;
        enable  = 1'b1;
        @(posedge clock);
        #(DRIVE_DELAY);
        enable = 1'b0;
        wait_idle();
        expected_memory[first_address] = first_data;
        if (frame_count != frames + 1)
            report_mismatch("frame_count", 16'(frames + 1), 16'(frame_count));
        if (last_frame !== {first_address, 1'b0, first_data})
            report_mismatch("slave frame", {first_address, 1'b0, first_data}, last_frame);
        // No pending command starts once the master is idle
        @(posedge clock);
        #(DRIVE_DELAY);
        if (busy !== 1'b0)
            report_mismatch("busy", 16'h0, {15'h0, busy});
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLOCK_PERIOD);
        $display("Watchdog expired before the tests finished");
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        void'($urandom(65422));
        reset_n     = 1'b0;
        enable      = 1'b0;
        address     = '0;
        read_write  = 1'b0;
        data        = '0;
        clock_phase = 1'b0;
        divider     = DIVIDER_WIDTH'(1);
        errors      = 0;
        for (int i = 0; i < 128; i++) begin
            expected_memory[i] = fill_pattern(i);
        end
        repeat (5) @(posedge clock);
        #(DRIVE_DELAY);
        reset_n = 1'b1;

        reset_state_test();
        for (int phase = 0; phase < 2; phase++) begin
            write_test(1'(phase), 1, 7'($urandom), 8'($urandom));
            read_back_test(1'(phase), 1, 4);
        end
        divider_test(0);
        divider_test(2);
        divider_test(5);
        enable_busy_test();

        $display("Finished with %0d check errors and %0d assertion failures",
                 errors, uut.properties.failures);
        if (errors == 0 && uut.properties.failures == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* spi_master.f */
hw/spi_frame_pkg.sv
hw/spi_timing_pkg.sv
hw/spi_bit_timer.sv
hw/spi_sequencer.sv
hw/spi_shift_transmit.sv
hw/spi_shift_receive.sv
hw/spi_master.sv
sim/spi_master_properties.sv
sim/spi_master_tb.sv
